// ==== mem_checker.f ====
design/ddr_addr_pkg.sv
design/axi4_pkg.sv
design/burst_addr_gen.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/mem_test_ctrl.sv
design/mem_checker_top.sv
sim/axi_mem_model.sv
sim/mem_checker_chk.sv
sim/tb_mem_checker.sv

// ==== Makefile ====
# Verilator build and run for the DDR memory test master

VERILATOR ?= verilator
TOP       ?= tb_mem_checker
FILELIST  ?= mem_checker.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_mem_checker.sv ====
`timescale 1ns/10ps

module tb_mem_checker;
	import ddr_addr_pkg::*;
	import axi4_pkg::*;

	// window placed so every ddr field is non-zero
	localparam int WIN_BYTES = 2048;
	localparam logic [ADDR_W-1:0] START_ADDR = 33'h1_0003_3000;
	localparam logic [ADDR_W-1:0] STOP_ADDR = START_ADDR + ADDR_W'(WIN_BYTES);
	localparam int BURST_BEATS = 4;
	localparam int LANE_W = 16;
	localparam int WIN_BEATS = WIN_BYTES / STRB_W;
	localparam int BURST_BYTES = BURST_BEATS * STRB_W;
	localparam int MAX_STALL = 8;
	// five reset-to-done runs after the idle check
	localparam int RUNS = 5;
	localparam int IDLE_CYCLES = 20;
	localparam int CYCLE_LIMIT = RUNS * WIN_BEATS * 2 * (MAX_STALL + 4) + IDLE_CYCLES;

	logic      iCLK;
	logic      iRST;
	logic      cfg_done;
	axi_ax_t   aw;
	logic      awvalid;
	logic      awready;
	axi_w_t    w;
	logic      wvalid;
	logic      wready;
	axi_b_t    b;
	logic      bvalid;
	logic      bready;
	axi_ax_t   ar;
	logic      arvalid;
	logic      arready;
	axi_r_t    r;
	logic      rvalid;
	logic      rready;
	logic      test_run;
	logic      test_done;
	logic      test_fail;
	ddr_addr_u fail_addr;
	logic      stall_en;
	int        fault_b;
	int        fault_r;
	int        flip_beat;
	int        cycle_cnt = 0;

	mem_checker_top #(
		.START_ADDR  (START_ADDR),
		.STOP_ADDR   (STOP_ADDR),
		.BURST_BEATS (BURST_BEATS),
		.LANE_W      (LANE_W)
	) uut (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_cfg_done  (cfg_done),
		.o_aw        (aw),
		.o_awvalid   (awvalid),
		.i_awready   (awready),
		.o_w         (w),
		.o_wvalid    (wvalid),
		.i_wready    (wready),
		.i_b         (b),
		.i_bvalid    (bvalid),
		.o_bready    (bready),
		.o_ar        (ar),
		.o_arvalid   (arvalid),
		.i_arready   (arready),
		.i_r         (r),
		.i_rvalid    (rvalid),
		.o_rready    (rready),
		.o_test_run  (test_run),
		.o_test_done (test_done),
		.o_test_fail (test_fail),
		.o_fail_addr (fail_addr)
	);

	axi_mem_model #(
		.BASE_ADDR (START_ADDR),
		.DEPTH     (WIN_BEATS)
	) u_mem (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_stall_en  (stall_en),
		.i_fault_b   (fault_b),
		.i_fault_r   (fault_r),
		.i_flip_beat (flip_beat),
		.i_aw        (aw),
		.i_awvalid   (awvalid),
		.o_awready   (awready),
		.i_w         (w),
		.i_wvalid    (wvalid),
		.o_wready    (wready),
		.o_b         (b),
		.o_bvalid    (bvalid),
		.i_bready    (bready),
		.i_ar        (ar),
		.i_arvalid   (arvalid),
		.o_arready   (arready),
		.o_r         (r),
		.o_rvalid    (rvalid),
		.i_rready    (rready)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	//--------------------------------------------------------------------------
	// failure exit and watchdog
	//--------------------------------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	always @(posedge iCLK)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			report_failure($sformatf("timeout, no finish within %0d cycles", CYCLE_LIMIT));
	end

	//--------------------------------------------------------------------------
	// compare tasks
	//--------------------------------------------------------------------------
	task automatic check_status(input string step, input logic run, input logic done,
		input logic fail);
		if ({test_run, test_done, test_fail} !== {run, done, fail})
			report_failure($sformatf("[ERROR] %s run/done/fail: got %h expected %h",
				step, {test_run, test_done, test_fail}, {run, done, fail}));
	endtask

	// field values sliced from the flat address by the ddr layout
	task automatic check_addr(input string step, input ddr_addr_u got, input ddr_addr_u exp);
		logic [16:0] exp_row;
		logic [2:0]  exp_bank;
		logic [9:0]  exp_col;
		string       got_s;
		string       exp_s;
		exp_row  = 17'(exp.flat >> 15);
		exp_bank = 3'(exp.flat >> 12);
		exp_col  = 10'(exp.flat >> 2);
		got_s = $sformatf("%h (row %h bank %h col %h)", got.flat, got.field.row,
			got.field.bank, got.field.col);
		exp_s = $sformatf("%h (row %h bank %h col %h)", exp.flat, exp_row, exp_bank, exp_col);
		if ((got.flat !== exp.flat) || (got.field.cs !== exp.flat[32])
			|| (got.field.row !== exp_row) || (got.field.bank !== exp_bank)
			|| (got.field.col !== exp_col))
			report_failure($sformatf("[ERROR] %s o_fail_addr: got %s expected %s",
				step, got_s, exp_s));
	endtask

	task automatic check_word(input string step, input int idx, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s mem[%0d]: got %h expected %h",
				step, idx, got, exp));
	endtask

	// beat count replicated into every lane
	function automatic logic [DATA_W-1:0] expected_beat(input int k);
		logic [DATA_W-1:0] word;
		for (int i = 0; i < DATA_W / LANE_W; i++)
			word[i*LANE_W +: LANE_W] = LANE_W'(k);
		return word;
	endfunction

	function automatic ddr_addr_u burst_address(input int burst);
		ddr_addr_u a;
		a.flat = START_ADDR + ADDR_W'(burst * BURST_BYTES);
		return a;
	endfunction

	//--------------------------------------------------------------------------
	// helpers
	//--------------------------------------------------------------------------
	task automatic apply_reset(input logic stall, input int bad_b, input int bad_r,
		input int flip);
		@(negedge iCLK);
		iRST      = 1'b1;
		cfg_done  = 1'b0;
		stall_en  = stall;
		fault_b   = bad_b;
		fault_r   = bad_r;
		flip_beat = flip;
		repeat (2) @(negedge iCLK);
		iRST = 1'b0;
	endtask

	task automatic run_to_done();
		@(negedge iCLK);
		cfg_done = 1'b1;
		while (!test_done)
			@(negedge iCLK);
	endtask

	task automatic check_memory(input string step);
		for (int k = 0; k < WIN_BEATS; k++)
			check_word(step, k, u_mem.mem[k], expected_beat(k));
	endtask

	//--------------------------------------------------------------------------
	// directed tests
	//--------------------------------------------------------------------------
	task automatic test_idle_gating();
		apply_reset(1'b0, -1, -1, -1);
		repeat (IDLE_CYCLES)
		begin
			@(negedge iCLK);
			check_status("idle", 1'b0, 1'b0, 1'b0);
			if (awvalid || wvalid || arvalid || bready || rready)
				report_failure("idle: bus activity before configuration done");
		end
	endtask

	task automatic test_clean_pass(input logic stall, input string step);
		ddr_addr_u zero;
		zero.flat = '0;
		apply_reset(stall, -1, -1, -1);
		run_to_done();
		check_status(step, 1'b0, 1'b1, 1'b0);
		check_addr(step, fail_addr, zero);
		check_memory(step);
	endtask

	task automatic test_data_corruption();
		// beat 37 sits in burst 9
		apply_reset(1'b0, -1, -1, 37);
		run_to_done();
		check_status("corrupt", 1'b0, 1'b1, 1'b1);
		check_addr("corrupt", fail_addr, burst_address(37 / BURST_BEATS));
	endtask

	task automatic test_write_resp_error();
		apply_reset(1'b0, 6, -1, -1);
		run_to_done();
		check_status("bresp", 1'b0, 1'b1, 1'b1);
		check_addr("bresp", fail_addr, burst_address(6));
	endtask

	task automatic test_read_resp_error();
		apply_reset(1'b1, -1, 20, -1);
		run_to_done();
		check_status("rresp", 1'b0, 1'b1, 1'b1);
		check_addr("rresp", fail_addr, burst_address(20));
	endtask

	initial
	begin
		iRST      = 1'b1;
		cfg_done  = 1'b0;
		stall_en  = 1'b0;
		fault_b   = -1;
		fault_r   = -1;
		flip_beat = -1;
		void'($urandom(98216));
		test_idle_gating();
		test_clean_pass(1'b0, "ready");
		test_clean_pass(1'b1, "stall");
		test_data_corruption();
		test_write_resp_error();
		test_read_resp_error();
		$display("Test OK");
		$finish;
	end

endmodule

// ==== sim/mem_checker_chk.sv ====
`timescale 1ns/10ps

module mem_checker_chk #(
	parameter int BURST_BEATS = 4
)(
	input logic              iCLK,
	input logic              iRST,
	input axi4_pkg::axi_ax_t o_aw,
	input logic              o_awvalid,
	input logic              i_awready,
	input axi4_pkg::axi_w_t  o_w,
	input logic              o_wvalid,
	input logic              i_wready,
	input axi4_pkg::axi_ax_t o_ar,
	input logic              o_arvalid,
	input logic              i_arready,
	input logic              i_bvalid,
	input logic              o_bready,
	input logic              i_rvalid,
	input logic              o_rready
);
	logic [8:0] w_beat;

	// beats seen in the current write burst
	always_ff @(posedge iCLK)
	begin
		if (iRST || (o_awvalid && i_awready))
			w_beat <= '0;
		else if (o_wvalid && i_wready)
			w_beat <= w_beat + 9'd1;
	end

	//--------------------------------------------------------------------------
	// valid holds, payload frozen while stalled
	//--------------------------------------------------------------------------
	aw_hold: assert property (@(posedge iCLK) disable iff (iRST)
		o_awvalid && !i_awready |=> o_awvalid && $stable(o_aw))
		else $error("aw valid dropped or payload changed while stalled");

	w_hold: assert property (@(posedge iCLK) disable iff (iRST)
		o_wvalid && !i_wready |=> o_wvalid && $stable(o_w))
		else $error("w valid dropped or payload changed while stalled");

	ar_hold: assert property (@(posedge iCLK) disable iff (iRST)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar))
		else $error("ar valid dropped or payload changed while stalled");

	// slave side of the same rule
	b_hold: assert property (@(posedge iCLK) disable iff (iRST)
		i_bvalid && !o_bready |=> i_bvalid)
		else $error("b valid dropped before ready");

	r_hold: assert property (@(posedge iCLK) disable iff (iRST)
		i_rvalid && !o_rready |=> i_rvalid)
		else $error("r valid dropped before ready");

	wlast_pos: assert property (@(posedge iCLK) disable iff (iRST)
		o_wvalid |-> (o_w.last == (w_beat == 9'(BURST_BEATS - 1))))
		else $error("wlast not on the final beat of the burst");

endmodule

bind mem_checker_top mem_checker_chk #(
	.BURST_BEATS (BURST_BEATS)
) u_chk (
	.iCLK      (iCLK),
	.iRST      (iRST),
	.o_aw      (o_aw),
	.o_awvalid (o_awvalid),
	.i_awready (i_awready),
	.o_w       (o_w),
	.o_wvalid  (o_wvalid),
	.i_wready  (i_wready),
	.o_ar      (o_ar),
	.o_arvalid (o_arvalid),
	.i_arready (i_arready),
	.i_bvalid  (i_bvalid),
	.o_bready  (o_bready),
	.i_rvalid  (i_rvalid),
	.o_rready  (o_rready)
);

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/10ps

module axi_mem_model #(
	parameter logic [ddr_addr_pkg::ADDR_W-1:0] BASE_ADDR = '0,
	parameter int DEPTH = 128
)(
	input  logic                     iCLK,
	input  logic                     iRST,
	input  logic                     i_stall_en,
	input  int                       i_fault_b,
	input  int                       i_fault_r,
	input  int                       i_flip_beat,
	input  axi4_pkg::axi_ax_t        i_aw,
	input  logic                     i_awvalid,
	output logic                     o_awready = 1'b0,
	input  axi4_pkg::axi_w_t         i_w,
	input  logic                     i_wvalid,
	output logic                     o_wready = 1'b0,
	output axi4_pkg::axi_b_t         o_b = '0,
	output logic                     o_bvalid = 1'b0,
	input  logic                     i_bready,
	input  axi4_pkg::axi_ax_t        i_ar,
	input  logic                     i_arvalid,
	output logic                     o_arready = 1'b0,
	output axi4_pkg::axi_r_t         o_r = '0,
	output logic                     o_rvalid = 1'b0,
	input  logic                     i_rready
);
	import ddr_addr_pkg::*;
	import axi4_pkg::*;

	logic [DATA_W-1:0] mem [DEPTH];

	int unsigned wr_idx = 0;
	int unsigned rd_idx = 0;
	logic [7:0]  wr_len = '0;
	logic [7:0]  w_beat = '0;
	logic [7:0]  rd_len = '0;
	logic [7:0]  r_beat = '0;
	logic        aw_got = 1'b0;
	logic        b_pend = 1'b0;
	logic        rd_busy = 1'b0;
	logic        b_taken = 1'b0;
	logic        r_taken = 1'b0;
	int          b_cnt = 0;
	int          r_cnt = 0;
	axi_resp_e   b_resp = OKAY;

	// byte address to word slot inside the window
	function automatic int unsigned word_index(input ddr_addr_u a);
		logic [ADDR_W-1:0] off;
		off = a.flat - BASE_ADDR;
		return 32'(off >> $clog2(STRB_W));
	endfunction

	// only strobed byte lanes take the new data
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] word;
		word = old;
		for (int j = 0; j < STRB_W; j++)
			if (strb[j])
				word[j*8 +: 8] = data[j*8 +: 8];
		return word;
	endfunction

	// one coin per channel per cycle when stalls are on
	function automatic logic ready_draw();
		if (!i_stall_en)
			return 1'b1;
		return (($urandom % 2) != 0);
	endfunction

	//--------------------------------------------------------------------------
	// handshake bookkeeping, sampled on the rising edge
	//--------------------------------------------------------------------------
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			aw_got  <= 1'b0;
			b_pend  <= 1'b0;
			rd_busy <= 1'b0;
			b_taken <= 1'b0;
			r_taken <= 1'b0;
			b_cnt   <= 0;
			r_cnt   <= 0;
			// fresh contents, every byte differs from the pattern word
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= {(DATA_W/32){~(32'(i) ^ 32'h5a5a_0000)}};
		end
		else
		begin
			b_taken <= o_bvalid & i_bready;
			r_taken <= o_rvalid & i_rready;
			if (i_awvalid && o_awready)
			begin
				aw_got <= 1'b1;
				wr_idx <= word_index(i_aw.addr);
				wr_len <= i_aw.len;
				w_beat <= '0;
			end
			if (i_wvalid && o_wready)
			begin
				mem[wr_idx] <= merge_bytes(mem[wr_idx], i_w.data, i_w.strb);
				wr_idx      <= wr_idx + 1;
				w_beat      <= w_beat + 8'd1;
				// burst length comes from the address phase
				if (w_beat == wr_len)
				begin
					b_pend <= 1'b1;
					b_resp <= (b_cnt == i_fault_b) ? SLVERR : OKAY;
				end
			end
			if (o_bvalid && i_bready)
			begin
				b_pend <= 1'b0;
				aw_got <= 1'b0;
				b_cnt  <= b_cnt + 1;
			end
			if (i_arvalid && o_arready)
			begin
				rd_busy <= 1'b1;
				rd_idx  <= word_index(i_ar.addr);
				rd_len  <= i_ar.len;
				r_beat  <= '0;
				// corrupt one stored beat once the fill is over
				if ((r_cnt == 0) && (i_flip_beat >= 0) && (i_flip_beat < DEPTH))
					mem[i_flip_beat] <= mem[i_flip_beat] ^ (DATA_W'(1) << 5);
			end
			if (o_rvalid && i_rready)
			begin
				rd_idx <= rd_idx + 1;
				r_beat <= r_beat + 8'd1;
				if (o_r.last)
				begin
					rd_busy <= 1'b0;
					r_cnt   <= r_cnt + 1;
				end
			end
		end
	end

	//--------------------------------------------------------------------------
	// slave outputs, driven on the falling edge
	//--------------------------------------------------------------------------
	always @(negedge iCLK)
	begin
		o_awready <= !aw_got && ready_draw();
		o_wready  <= aw_got && !b_pend && ready_draw();
		o_arready <= !rd_busy && ready_draw();
		// a pending response holds until taken
		if (!o_bvalid || b_taken)
		begin
			o_bvalid <= b_pend && ready_draw();
			o_b.resp <= b_resp;
		end
		if (!o_rvalid || r_taken)
		begin
			o_rvalid  <= rd_busy && ready_draw();
			o_r.data  <= (rd_idx < DEPTH) ? mem[rd_idx] : '0;
			o_r.resp  <= (r_cnt == i_fault_r) ? SLVERR : OKAY;
			o_r.last  <= (r_beat == rd_len);
		end
	end

endmodule

// ==== design/mem_checker_top.sv ====
`timescale 1ns/10ps

module mem_checker_top #(
	parameter logic [ddr_addr_pkg::ADDR_W-1:0] START_ADDR = 33'h0_0000_0000,
	parameter logic [ddr_addr_pkg::ADDR_W-1:0] STOP_ADDR = 33'h0_0000_0800,
	parameter int BURST_BEATS = 4,
	parameter int LANE_W = 16
)(
	input  logic                    iCLK,
	input  logic                    iRST,
	input  logic                    i_cfg_done,
	// write address
	output axi4_pkg::axi_ax_t       o_aw,
	output logic                    o_awvalid,
	input  logic                    i_awready,
	// write data
	output axi4_pkg::axi_w_t        o_w,
	output logic                    o_wvalid,
	input  logic                    i_wready,
	// write response
	input  axi4_pkg::axi_b_t        i_b,
	input  logic                    i_bvalid,
	output logic                    o_bready,
	// read address
	output axi4_pkg::axi_ax_t       o_ar,
	output logic                    o_arvalid,
	input  logic                    i_arready,
	// read data
	input  axi4_pkg::axi_r_t        i_r,
	input  logic                    i_rvalid,
	output logic                    o_rready,
	// test status
	output logic                    o_test_run,
	output logic                    o_test_done,
	output logic                    o_test_fail,
	output ddr_addr_pkg::ddr_addr_u o_fail_addr
);
	import ddr_addr_pkg::*;

	logic      wr_start;
	logic      rd_start;
	logic      clear;
	logic      wr_step;
	logic      rd_step;
	logic      wr_done;
	logic      wr_err;
	logic      wr_last;
	logic      rd_done;
	logic      rd_err;
	logic      rd_mis;
	logic      rd_last;
	ddr_addr_u wr_addr;
	ddr_addr_u rd_addr;

	//--------------------------------------------------------------------------
	// sequencing
	//--------------------------------------------------------------------------
	mem_test_ctrl u_ctrl (
		.iCLK          (iCLK),
		.iRST          (iRST),
		.i_cfg_done    (i_cfg_done),
		.i_wr_done     (wr_done),
		.i_wr_err      (wr_err),
		.i_wr_last     (wr_last),
		.i_wr_addr     (wr_addr),
		.i_rd_done     (rd_done),
		.i_rd_err      (rd_err),
		.i_rd_mismatch (rd_mis),
		.i_rd_last     (rd_last),
		.i_rd_addr     (rd_addr),
		.o_wr_start    (wr_start),
		.o_rd_start    (rd_start),
		.o_clear       (clear),
		.o_wr_step     (wr_step),
		.o_rd_step     (rd_step),
		.o_test_run    (o_test_run),
		.o_test_done   (o_test_done),
		.o_test_fail   (o_test_fail),
		.o_fail_addr   (o_fail_addr)
	);

	// one address walker per direction
	burst_addr_gen #(
		.START_ADDR  (START_ADDR),
		.STOP_ADDR   (STOP_ADDR),
		.BURST_BEATS (BURST_BEATS)
	) u_wr_addr (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.i_clear (clear),
		.i_step  (wr_step),
		.o_addr  (wr_addr),
		.o_last  (wr_last)
	);

	burst_addr_gen #(
		.START_ADDR  (START_ADDR),
		.STOP_ADDR   (STOP_ADDR),
		.BURST_BEATS (BURST_BEATS)
	) u_rd_addr (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.i_clear (clear),
		.i_step  (rd_step),
		.o_addr  (rd_addr),
		.o_last  (rd_last)
	);

	//--------------------------------------------------------------------------
	// bus engines
	//--------------------------------------------------------------------------
	axi_write_engine #(
		.BURST_BEATS (BURST_BEATS),
		.LANE_W      (LANE_W)
	) u_wr_eng (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.i_start      (wr_start),
		.i_clear      (clear),
		.i_addr       (wr_addr),
		.o_aw         (o_aw),
		.o_awvalid    (o_awvalid),
		.i_awready    (i_awready),
		.o_w          (o_w),
		.o_wvalid     (o_wvalid),
		.i_wready     (i_wready),
		.i_b          (i_b),
		.i_bvalid     (i_bvalid),
		.o_bready     (o_bready),
		.o_burst_done (wr_done),
		.o_resp_err   (wr_err)
	);

	axi_read_engine #(
		.BURST_BEATS (BURST_BEATS),
		.LANE_W      (LANE_W)
	) u_rd_eng (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.i_start      (rd_start),
		.i_clear      (clear),
		.i_addr       (rd_addr),
		.o_ar         (o_ar),
		.o_arvalid    (o_arvalid),
		.i_arready    (i_arready),
		.i_r          (i_r),
		.i_rvalid     (i_rvalid),
		.o_rready     (o_rready),
		.o_burst_done (rd_done),
		.o_resp_err   (rd_err),
		.o_mismatch   (rd_mis)
	);

endmodule

// ==== design/mem_test_ctrl.sv ====
`timescale 1ns/10ps

module mem_test_ctrl (
	input  logic                    iCLK,
	input  logic                    iRST,
	input  logic                    i_cfg_done,
	input  logic                    i_wr_done,
	input  logic                    i_wr_err,
	input  logic                    i_wr_last,
	input  ddr_addr_pkg::ddr_addr_u i_wr_addr,
	input  logic                    i_rd_done,
	input  logic                    i_rd_err,
	input  logic                    i_rd_mismatch,
	input  logic                    i_rd_last,
	input  ddr_addr_pkg::ddr_addr_u i_rd_addr,
	output logic                    o_wr_start,
	output logic                    o_rd_start,
	output logic                    o_clear,
	output logic                    o_wr_step,
	output logic                    o_rd_step,
	output logic                    o_test_run,
	output logic                    o_test_done,
	output logic                    o_test_fail,
	output ddr_addr_pkg::ddr_addr_u o_fail_addr
);
	typedef enum logic [1:0] {s_idle, s_write, s_read, s_done} ctrl_state_e;

	ctrl_state_e state;

	// advance the address generator on every finished burst
	assign o_wr_step = (state == s_write) & i_wr_done;
	assign o_rd_step = (state == s_read) & i_rd_done;

	//--------------------------------------------------------------------------
	// phase sequencer
	//--------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state       <= s_idle;
			o_wr_start  <= 1'b0;
			o_rd_start  <= 1'b0;
			o_clear     <= 1'b0;
			o_test_run  <= 1'b0;
			o_test_done <= 1'b0;
			o_test_fail <= 1'b0;
			o_fail_addr <= '0;
		end
		else
		begin
			o_wr_start <= 1'b0;
			o_rd_start <= 1'b0;
			o_clear    <= 1'b0;
			case (state)
				s_idle:
				begin
					// controller calibrated, start filling
					if (i_cfg_done)
					begin
						o_clear    <= 1'b1;
						o_wr_start <= 1'b1;
						o_test_run <= 1'b1;
						state      <= s_write;
					end
				end
				s_write:
				begin
					if (i_wr_done)
					begin
						if (i_wr_err)
						begin
							o_fail_addr <= i_wr_addr;
							o_test_fail <= 1'b1;
							o_test_run  <= 1'b0;
							o_test_done <= 1'b1;
							state       <= s_done;
						end
						else if (i_wr_last)
						begin
							o_rd_start <= 1'b1;
							state      <= s_read;
						end
						else
							o_wr_start <= 1'b1;
					end
				end
				s_read:
				begin
					if (i_rd_done)
					begin
						// bad data or bad response stops the test
						if (i_rd_err || i_rd_mismatch)
						begin
							o_fail_addr <= i_rd_addr;
							o_test_fail <= 1'b1;
							o_test_run  <= 1'b0;
							o_test_done <= 1'b1;
							state       <= s_done;
						end
						else if (i_rd_last)
						begin
							o_test_run  <= 1'b0;
							o_test_done <= 1'b1;
							state       <= s_done;
						end
						else
							o_rd_start <= 1'b1;
					end
				end
				// results hold until the next reset
				default:
					state <= s_done;
			endcase
		end
	end

endmodule

// ==== design/axi_read_engine.sv ====
`timescale 1ns/10ps

module axi_read_engine #(
	parameter int BURST_BEATS = 4,
	parameter int LANE_W = 16
)(
	input  logic                    iCLK,
	input  logic                    iRST,
	input  logic                    i_start,
	input  logic                    i_clear,
	input  ddr_addr_pkg::ddr_addr_u i_addr,
	output axi4_pkg::axi_ax_t       o_ar,
	output logic                    o_arvalid,
	input  logic                    i_arready,
	input  axi4_pkg::axi_r_t        i_r,
	input  logic                    i_rvalid,
	output logic                    o_rready,
	output logic                    o_burst_done,
	output logic                    o_resp_err,
	output logic                    o_mismatch
);
	import ddr_addr_pkg::*;
	import axi4_pkg::*;

	localparam int LANES = DATA_W / LANE_W;

	typedef enum logic [1:0] {s_idle, s_addr, s_data} rd_state_e;

	rd_state_e         state;
	ddr_addr_u         addr_q;
	logic [LANE_W-1:0] exp_cnt;
	logic [LANES-1:0]  lane_bad;
	logic              resp_bad;
	logic              cmp_vld;
	logic              cmp_last;
	logic              acc_mis;
	logic              acc_resp;
	logic              ar_hs;
	logic              r_hs;

	assign ar_hs = o_arvalid & i_arready;
	assign r_hs  = i_rvalid & o_rready;

	//--------------------------------------------------------------------------
	// address and data handshakes
	//--------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state     <= s_idle;
			o_arvalid <= 1'b0;
			o_rready  <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (i_start)
					begin
						o_arvalid <= 1'b1;
						state     <= s_addr;
					end
				end
				s_addr:
				begin
					if (ar_hs)
					begin
						o_arvalid <= 1'b0;
						o_rready  <= 1'b1;
						state     <= s_data;
					end
				end
				s_data:
				begin
					// slave marks the end of the burst
					if (r_hs && i_r.last)
					begin
						o_rready <= 1'b0;
						state    <= s_idle;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge iCLK)
	begin
		if ((state == s_idle) && i_start)
			addr_q <= i_addr;
	end

	// expected count, one step per beat
	always_ff @(posedge iCLK)
	begin
		if (iRST || i_clear)
			exp_cnt <= '0;
		else if (r_hs)
			exp_cnt <= exp_cnt + 1'b1;
	end

	//--------------------------------------------------------------------------
	// compare stage, one cycle behind the beat
	//--------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (r_hs)
		begin
			for (int i = 0; i < LANES; i++)
				lane_bad[i] <= (i_r.data[i*LANE_W +: LANE_W] != exp_cnt);
			resp_bad <= (i_r.resp != OKAY);
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			cmp_vld  <= 1'b0;
			cmp_last <= 1'b0;
		end
		else
		begin
			cmp_vld  <= r_hs;
			cmp_last <= r_hs & i_r.last;
		end
	end

	// sticky flags over one burst
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			acc_mis      <= 1'b0;
			acc_resp     <= 1'b0;
			o_burst_done <= 1'b0;
			o_mismatch   <= 1'b0;
			o_resp_err   <= 1'b0;
		end
		else
		begin
			o_burst_done <= 1'b0;
			o_mismatch   <= 1'b0;
			o_resp_err   <= 1'b0;
			if ((state == s_idle) && i_start)
			begin
				acc_mis  <= 1'b0;
				acc_resp <= 1'b0;
			end
			else if (cmp_vld)
			begin
				acc_mis  <= acc_mis | (|lane_bad);
				acc_resp <= acc_resp | resp_bad;
				// last beat compared, report the whole burst
				if (cmp_last)
				begin
					o_burst_done <= 1'b1;
					o_mismatch   <= acc_mis | (|lane_bad);
					o_resp_err   <= acc_resp | resp_bad;
				end
			end
		end
	end

	always_comb
	begin
		o_ar.addr = addr_q;
		o_ar.len  = LEN_W'(BURST_BEATS - 1);
	end

endmodule

// ==== design/axi_write_engine.sv ====
`timescale 1ns/10ps

module axi_write_engine #(
	parameter int BURST_BEATS = 4,
	parameter int LANE_W = 16
)(
	input  logic                    iCLK,
	input  logic                    iRST,
	input  logic                    i_start,
	input  logic                    i_clear,
	input  ddr_addr_pkg::ddr_addr_u i_addr,
	output axi4_pkg::axi_ax_t       o_aw,
	output logic                    o_awvalid,
	input  logic                    i_awready,
	output axi4_pkg::axi_w_t        o_w,
	output logic                    o_wvalid,
	input  logic                    i_wready,
	input  axi4_pkg::axi_b_t        i_b,
	input  logic                    i_bvalid,
	output logic                    o_bready,
	output logic                    o_burst_done,
	output logic                    o_resp_err
);
	import ddr_addr_pkg::*;
	import axi4_pkg::*;

	localparam int LANES = DATA_W / LANE_W;
	localparam int BEAT_W = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_BEATS - 1);

	typedef enum logic [1:0] {s_idle, s_addr, s_data, s_resp} wr_state_e;

	wr_state_e         state;
	ddr_addr_u         addr_q;
	logic [BEAT_W-1:0] beat_cnt;
	logic [LANE_W-1:0] lane_cnt;
	logic              aw_hs;
	logic              w_hs;
	logic              b_hs;

	assign aw_hs = o_awvalid & i_awready;
	assign w_hs  = o_wvalid & i_wready;
	assign b_hs  = o_bready & i_bvalid;

	//--------------------------------------------------------------------------
	// burst sequencer
	//--------------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state        <= s_idle;
			o_awvalid    <= 1'b0;
			o_wvalid     <= 1'b0;
			o_bready     <= 1'b0;
			o_burst_done <= 1'b0;
			o_resp_err   <= 1'b0;
		end
		else
		begin
			// single cycle status strobes
			o_burst_done <= 1'b0;
			o_resp_err   <= 1'b0;
			case (state)
				s_idle:
				begin
					if (i_start)
					begin
						o_awvalid <= 1'b1;
						state     <= s_addr;
					end
				end
				s_addr:
				begin
					// address taken, data beats follow
					if (aw_hs)
					begin
						o_awvalid <= 1'b0;
						o_wvalid  <= 1'b1;
						state     <= s_data;
					end
				end
				s_data:
				begin
					if (w_hs && (beat_cnt == LAST_BEAT))
					begin
						o_wvalid <= 1'b0;
						o_bready <= 1'b1;
						state    <= s_resp;
					end
				end
				s_resp:
				begin
					if (b_hs)
					begin
						o_bready     <= 1'b0;
						o_burst_done <= 1'b1;
						o_resp_err   <= (i_b.resp != OKAY);
						state        <= s_idle;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// burst address held for the whole burst
	always_ff @(posedge iCLK)
	begin
		if ((state == s_idle) && i_start)
			addr_q <= i_addr;
	end

	// beat position inside the burst
	always_ff @(posedge iCLK)
	begin
		if (iRST || aw_hs)
			beat_cnt <= '0;
		else if (w_hs)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// pattern counter runs across the whole window
	always_ff @(posedge iCLK)
	begin
		if (iRST || i_clear)
			lane_cnt <= '0;
		else if (w_hs)
			lane_cnt <= lane_cnt + 1'b1;
	end

	always_comb
	begin
		o_aw.addr = addr_q;
		o_aw.len  = LEN_W'(BURST_BEATS - 1);
		// same count in every lane
		o_w.data  = {LANES{lane_cnt}};
		o_w.strb  = '1;
		o_w.last  = (beat_cnt == LAST_BEAT);
	end

endmodule

// ==== design/burst_addr_gen.sv ====
`timescale 1ns/10ps

module burst_addr_gen #(
	parameter logic [ddr_addr_pkg::ADDR_W-1:0] START_ADDR = '0,
	parameter logic [ddr_addr_pkg::ADDR_W-1:0] STOP_ADDR = 33'h0_0000_0800,
	parameter int BURST_BEATS = 4
)(
	input  logic                    iCLK,
	input  logic                    iRST,
	input  logic                    i_clear,
	input  logic                    i_step,
	output ddr_addr_pkg::ddr_addr_u o_addr,
	output logic                    o_last
);
	import ddr_addr_pkg::*;
	import axi4_pkg::*;

	// bytes covered by one burst
	localparam logic [ADDR_W-1:0] STEP = ADDR_W'(BURST_BEATS * STRB_W);

	ddr_addr_u         addr_q;
	logic [ADDR_W-1:0] addr_nxt;

	// next burst start
	assign addr_nxt = addr_q.flat + STEP;

	// window start on reset or clear, one burst per step
	always_ff @(posedge iCLK)
	begin
		if (iRST || i_clear)
			addr_q.flat <= START_ADDR;
		else if (i_step)
			addr_q.flat <= addr_nxt;
	end

	assign o_addr = addr_q;
	// stop is exclusive, so this burst is the final one
	assign o_last = (addr_nxt >= STOP_ADDR);

endmodule

// ==== design/axi4_pkg.sv ====
package axi4_pkg;

	//--------------------------------------------------------------------------
	// bus geometry
	//--------------------------------------------------------------------------

	// data bus width in bits
	localparam int DATA_W = 128;
	// one strobe per byte lane
	localparam int STRB_W = DATA_W / 8;
	// burst length field, beats minus one
	localparam int LEN_W = 8;

	// response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	//--------------------------------------------------------------------------
	// channel payloads, valid and ready travel beside them
	//--------------------------------------------------------------------------

	// shared by aw and ar
	// size and burst type are always full width incrementing
	typedef struct packed {
		ddr_addr_pkg::ddr_addr_u addr;
		logic [LEN_W-1:0]        len;
	} axi_ax_t;

	// write data beat
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} axi_w_t;

	// read data beat
	typedef struct packed {
		logic [DATA_W-1:0] data;
		axi_resp_e         resp;
		logic              last;
	} axi_r_t;

	// write response
	typedef struct packed {
		axi_resp_e resp;
	} axi_b_t;

endpackage

// ==== design/ddr_addr_pkg.sv ====
package ddr_addr_pkg;

	//--------------------------------------------------------------------------
	// ddr address layout as seen on the axi address bus
	//--------------------------------------------------------------------------

	// chip select, top bit
	localparam int CS_W = 1;
	// row address
	localparam int ROW_W = 17;
	// bank address
	localparam int BANK_W = 3;
	// column address
	localparam int COL_W = 10;
	// datapath select, lowest bits
	localparam int DP_W = 2;

	// full axi byte address, 33 bits
	localparam int ADDR_W = CS_W + ROW_W + BANK_W + COL_W + DP_W;

	// field order is msb first
	typedef struct packed {
		logic [CS_W-1:0]   cs;
		logic [ROW_W-1:0]  row;
		logic [BANK_W-1:0] bank;
		logic [COL_W-1:0]  col;
		logic [DP_W-1:0]   dp;
	} ddr_addr_t;

	// two views of one address word
	// flat for counting and range compare
	// field for reporting a ddr location
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		ddr_addr_t         field;
	} ddr_addr_u;

endpackage
